//--- backend_pkg.sv
package backend_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int PREG_COUNT = 64;
    localparam int PREG_W     = 6;
    localparam int ROB_TAG_W  = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // operation codes, OP_MUL goes to the multiplier and all others to the ALU
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLT = 4'd5,
        OP_SLL = 4'd6,
        OP_SRL = 4'd7,
        OP_LI  = 4'd8,
        OP_MUL = 4'd9
    } fu_op_e;

    // renamed micro-op from dispatch
    typedef struct packed {
        rob_tag_t tag;
        fu_op_e   op;
        preg_t    prd;
        preg_t    prs1;
        preg_t    prs2;
        logic     use_imm;
        word_t    imm;
    } uop_t;

    // issued micro-op with operand values
    typedef struct packed {
        rob_tag_t tag;
        fu_op_e   op;
        preg_t    prd;
        word_t    a;
        word_t    b;
    } exec_req_t;

    // result on its way to the register file
    typedef struct packed {
        rob_tag_t tag;
        preg_t    prd;
        word_t    data;
    } wb_t;

endpackage

//--- scoreboard.sv
`timescale 1ns/1ps

module scoreboard import backend_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  set_en_i,
    input  preg_t                 set_preg_i,
    input  logic                  clr_en_i,
    input  preg_t                 clr_preg_i,
    output logic [PREG_COUNT-1:0] busy_o
);

    logic [PREG_COUNT-1:0] busy_q;

    // clear first so a set in the same cycle always lands
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            if (clr_en_i) begin
                busy_q[clr_preg_i] <= 1'b0;
            end
            if (set_en_i) begin
                busy_q[set_preg_i] <= 1'b1;
            end
        end
    end

    assign busy_o = busy_q;

    // dispatch may only name a free destination, or one being written back now
    assert property (@(posedge clk) disable iff (reset_i)
        set_en_i |-> (!busy_q[set_preg_i] || (clr_en_i && clr_preg_i == set_preg_i)))
        else $error("scoreboard: dispatch to busy preg %0d", set_preg_i);

endmodule

//--- issue_queue.sv
`timescale 1ns/1ps

module issue_queue import backend_pkg::*; #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  dispatch_valid_i,
    input  uop_t                  dispatch_uop_i,
    output logic                  dispatch_ready_o,
    input  logic [PREG_COUNT-1:0] busy_i,
    output preg_t                 rs1_o,
    output preg_t                 rs2_o,
    input  word_t                 rdata1_i,
    input  word_t                 rdata2_i,
    output logic                  alu_req_valid_o,
    output exec_req_t             alu_req_o,
    input  logic                  alu_ready_i,
    output logic                  mul_req_valid_o,
    output exec_req_t             mul_req_o,
    input  logic                  mul_ready_i,
    output logic                  sb_set_en_o,
    output preg_t                 sb_set_preg_o
);

    localparam int IDX_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    // compacting queue, slot 0 is always the oldest
    uop_t             ent_q [IQ_DEPTH];
    logic [CNT_W-1:0] count_q;

    logic [IQ_DEPTH-1:0] cand;
    logic                sel_found;
    logic [IDX_W-1:0]    sel_idx;
    uop_t                sel_uop;
    logic                sel_is_mul;
    exec_req_t           req;
    logic                push;
    logic [IDX_W-1:0]    wr_idx;

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            cand[i] = (CNT_W'(i) < count_q)
                && (ent_q[i].op == OP_LI || !busy_i[ent_q[i].prs1])
                && (ent_q[i].use_imm || !busy_i[ent_q[i].prs2])
                && ((ent_q[i].op == OP_MUL) ? mul_ready_i : alu_ready_i);
        end
    end

    // oldest ready entry wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!sel_found && cand[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign sel_uop    = ent_q[sel_idx];
    assign sel_is_mul = (sel_uop.op == OP_MUL);
    assign rs1_o      = sel_uop.prs1;
    assign rs2_o      = sel_uop.prs2;

    always_comb begin
        req.tag = sel_uop.tag;
        req.op  = sel_uop.op;
        req.prd = sel_uop.prd;
        req.a   = rdata1_i;
        req.b   = sel_uop.use_imm ? sel_uop.imm : rdata2_i;
    end

    assign alu_req_valid_o = sel_found && !sel_is_mul;
    assign mul_req_valid_o = sel_found && sel_is_mul;
    assign alu_req_o       = req;
    assign mul_req_o       = req;

    assign dispatch_ready_o = (count_q != CNT_W'(IQ_DEPTH));
    assign push             = dispatch_valid_i && dispatch_ready_o;
    assign sb_set_en_o      = push;
    assign sb_set_preg_o    = dispatch_uop_i.prd;
    assign wr_idx           = IDX_W'(count_q - CNT_W'(sel_found));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + CNT_W'(push) - CNT_W'(sel_found);
        end
    end

    // close the gap left by the issued entry, new one goes behind the rest
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH - 1; i++) begin
            if (sel_found && IDX_W'(i) >= sel_idx) begin
                ent_q[i] <= ent_q[i + 1];
            end
        end
        if (push) begin
            ent_q[wr_idx] <= dispatch_uop_i;
        end
    end

    // an issuing micro-op still owns its destination on the scoreboard
    assert property (@(posedge clk) disable iff (reset_i)
        sel_found |-> busy_i[sel_uop.prd])
        else $error("issue_queue: tag %0d issues to idle preg %0d",
                    sel_uop.tag, sel_uop.prd);

endmodule

//--- prf.sv
`timescale 1ns/1ps

module prf import backend_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  preg_t raddr1_i,
    input  preg_t raddr2_i,
    output word_t rdata1_o,
    output word_t rdata2_o,
    input  logic  we_i,
    input  wb_t   wb_i
);

    word_t regs_q [PREG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[wb_i.prd] <= wb_i.data;
        end
    end

    // no bypass, a write is visible from the next cycle
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

//--- alu_pipe.sv
`timescale 1ns/1ps

module alu_pipe import backend_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output wb_t       res_o,
    input  logic      grant_i
);

    logic  res_valid_q;
    wb_t   res_q;
    word_t alu_result;

    always_comb begin
        case (req_i.op)
            OP_ADD:  alu_result = req_i.a + req_i.b;
            OP_SUB:  alu_result = req_i.a - req_i.b;
            OP_AND:  alu_result = req_i.a & req_i.b;
            OP_OR:   alu_result = req_i.a | req_i.b;
            OP_XOR:  alu_result = req_i.a ^ req_i.b;
            OP_SLT:  alu_result = word_t'($signed(req_i.a) < $signed(req_i.b));
            OP_SLL:  alu_result = req_i.a << req_i.b[4:0];
            OP_SRL:  alu_result = req_i.a >> req_i.b[4:0];
            OP_LI:   alu_result = req_i.b;
            default: alu_result = '0;
        endcase
    end

    // free slot, or the held result leaves this cycle
    assign ready_o = !res_valid_q || grant_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else if (req_valid_i && ready_o) begin
            res_valid_q <= 1'b1;
        end else if (grant_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && ready_o) begin
            res_q.tag  <= req_i.tag;
            res_q.prd  <= req_i.prd;
            res_q.data <= alu_result;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

//--- mul_unit.sv
`timescale 1ns/1ps

module mul_unit import backend_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      ready_o,
    output logic      res_valid_o,
    output wb_t       res_o,
    input  logic      grant_i
);

    localparam int CNT_W = $clog2(XLEN);

    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    word_t            acc_q;
    word_t            mcand_q;
    word_t            mplier_q;
    rob_tag_t         tag_q;
    preg_t            prd_q;
    logic             accept;

    assign ready_o = !busy_q && !done_q;
    assign accept  = req_valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(XLEN - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (done_q && grant_i) begin
            done_q <= 1'b0;
        end
    end

    // one multiplier bit per cycle, only the low word is kept
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q    <= '0;
            mcand_q  <= req_i.a;
            mplier_q <= req_i.b;
            tag_q    <= req_i.tag;
            prd_q    <= req_i.prd;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign res_valid_o = done_q;
    assign res_o.tag   = tag_q;
    assign res_o.prd   = prd_q;
    assign res_o.data  = acc_q;

    // issue queue must hold multiplies back while this unit is occupied
    assert property (@(posedge clk) disable iff (reset_i)
        req_valid_i |-> ready_o && req_i.op == OP_MUL)
        else $error("mul_unit: request while busy or wrong op %0d", req_i.op);

endmodule

//--- wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import backend_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    input  logic alu_valid_i,
    input  wb_t  alu_res_i,
    input  logic mul_valid_i,
    input  wb_t  mul_res_i,
    output logic alu_grant_o,
    output logic mul_grant_o,
    output logic wb_valid_o,
    output wb_t  wb_o
);

    // set when the multiplier won the last contested or single grant
    logic last_mul_q;

    assign alu_grant_o = alu_valid_i && (!mul_valid_i || last_mul_q);
    assign mul_grant_o = mul_valid_i && (!alu_valid_i || !last_mul_q);
    assign wb_valid_o  = alu_grant_o || mul_grant_o;
    assign wb_o        = mul_grant_o ? mul_res_i : alu_res_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_mul_q <= 1'b0;
        end else if (mul_grant_o) begin
            last_mul_q <= 1'b1;
        end else if (alu_grant_o) begin
            last_mul_q <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        !(alu_grant_o && mul_grant_o))
        else $error("wb_arbiter: both units granted");

    // units hold their result, so a loser is served on the next edge
    assert property (@(posedge clk) disable iff (reset_i)
        (alu_valid_i && !alu_grant_o) |=> alu_grant_o)
        else $error("wb_arbiter: alu result starved");

endmodule

//--- backend_top.sv
`timescale 1ns/1ps

module backend_top import backend_pkg::*; #(
    parameter int IQ_DEPTH = 8
) (
    input  logic clk,
    input  logic reset_i,
    input  logic dispatch_valid_i,
    input  uop_t dispatch_uop_i,
    output logic dispatch_ready_o,
    output logic wb_valid_o,
    output wb_t  wb_o
);

    logic [PREG_COUNT-1:0] busy;
    logic                  sb_set_en;
    preg_t                 sb_set_preg;
    preg_t                 rs1;
    preg_t                 rs2;
    word_t                 rdata1;
    word_t                 rdata2;

    logic      alu_req_valid;
    exec_req_t alu_req;
    logic      alu_ready;
    logic      mul_req_valid;
    exec_req_t mul_req;
    logic      mul_ready;

    logic alu_res_valid;
    wb_t  alu_res;
    logic alu_grant;
    logic mul_res_valid;
    wb_t  mul_res;
    logic mul_grant;

    scoreboard u_scoreboard (
        .clk        (clk),
        .reset_i    (reset_i),
        .set_en_i   (sb_set_en),
        .set_preg_i (sb_set_preg),
        .clr_en_i   (wb_valid_o),
        .clr_preg_i (wb_o.prd),
        .busy_o     (busy)
    );

    issue_queue #(.IQ_DEPTH(IQ_DEPTH)) u_issue_queue (
        .clk              (clk),
        .reset_i          (reset_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .dispatch_ready_o (dispatch_ready_o),
        .busy_i           (busy),
        .rs1_o            (rs1),
        .rs2_o            (rs2),
        .rdata1_i         (rdata1),
        .rdata2_i         (rdata2),
        .alu_req_valid_o  (alu_req_valid),
        .alu_req_o        (alu_req),
        .alu_ready_i      (alu_ready),
        .mul_req_valid_o  (mul_req_valid),
        .mul_req_o        (mul_req),
        .mul_ready_i      (mul_ready),
        .sb_set_en_o      (sb_set_en),
        .sb_set_preg_o    (sb_set_preg)
    );

    prf u_prf (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (wb_valid_o),
        .wb_i     (wb_o)
    );

    alu_pipe u_alu_pipe (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (alu_req_valid),
        .req_i       (alu_req),
        .ready_o     (alu_ready),
        .res_valid_o (alu_res_valid),
        .res_o       (alu_res),
        .grant_i     (alu_grant)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (mul_req_valid),
        .req_i       (mul_req),
        .ready_o     (mul_ready),
        .res_valid_o (mul_res_valid),
        .res_o       (mul_res),
        .grant_i     (mul_grant)
    );

    wb_arbiter u_wb_arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .alu_valid_i (alu_res_valid),
        .alu_res_i   (alu_res),
        .mul_valid_i (mul_res_valid),
        .mul_res_i   (mul_res),
        .alu_grant_o (alu_grant),
        .mul_grant_o (mul_grant),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

endmodule

//--- tb_backend.sv
`timescale 1ns/1ps

module tb_backend import backend_pkg::*;;

    localparam int IQ_DEPTH    = 8;
    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = NUM_TESTS * 200;
    localparam int TAG_COUNT   = 1 << ROB_TAG_W;

    logic clk = 1'b0;
    logic reset_i;
    logic dispatch_valid_i;
    uop_t dispatch_uop_i;
    logic dispatch_ready_o;
    logic wb_valid_o;
    wb_t  wb_o;

    // reference model
    word_t    exp_reg  [PREG_COUNT];
    preg_t    exp_prd  [TAG_COUNT];
    word_t    exp_data [TAG_COUNT];
    logic     pending  [TAG_COUNT];
    logic     written  [TAG_COUNT];
    int       wb_cycle [TAG_COUNT];
    int       outstanding = 0;
    int       cycles = 0;
    rob_tag_t next_tag;
    preg_t    next_preg;
    int       seed;

    backend_top #(.IQ_DEPTH(IQ_DEPTH)) DUT (
        .clk              (clk),
        .reset_i          (reset_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .dispatch_ready_o (dispatch_ready_o),
        .wb_valid_o       (wb_valid_o),
        .wb_o             (wb_o)
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no completion within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // writebacks sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_i && wb_valid_o) begin
            if (!pending[wb_o.tag]) begin
                if (written[wb_o.tag]) begin
                    $display("tag %0d was written back twice at %0t", wb_o.tag, $time);
                    stop_run();
                end else begin
                    $display("writeback with unknown tag %0d at %0t", wb_o.tag, $time);
                    stop_run();
                end
            end else begin
                check_value("wb_o.prd", 32'(wb_o.prd), 32'(exp_prd[wb_o.tag]));
                check_value("wb_o.data", wb_o.data, exp_data[wb_o.tag]);
                pending[wb_o.tag]  = 1'b0;
                written[wb_o.tag]  = 1'b1;
                wb_cycle[wb_o.tag] = cycles;
                outstanding        = outstanding - 1;
            end
        end
    end

    function automatic word_t model_result(input fu_op_e op, input word_t a, input word_t b);
        word_t r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_LI:   r = b;
            OP_MUL:  r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic fresh_preg(output preg_t p);
        p = next_preg;
        next_preg = (next_preg == preg_t'(PREG_COUNT - 1)) ? preg_t'(1) : next_preg + preg_t'(1);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the transfer edge
    task automatic send(input fu_op_e op, input preg_t prd, input preg_t prs1,
                        input preg_t prs2, input logic use_imm, input word_t imm,
                        output rob_tag_t tag);
        uop_t  u;
        word_t a;
        word_t b;
        while (pending[next_tag]) begin
            @(posedge clk);
            #1;
        end
        tag      = next_tag;
        next_tag = next_tag + rob_tag_t'(1);
        a = exp_reg[prs1];
        b = use_imm ? imm : exp_reg[prs2];
        exp_prd[tag]  = prd;
        exp_data[tag] = model_result(op, a, b);
        exp_reg[prd]  = exp_data[tag];
        pending[tag]  = 1'b1;
        written[tag]  = 1'b0;
        outstanding   = outstanding + 1;
        u.tag     = tag;
        u.op      = op;
        u.prd     = prd;
        u.prs1    = prs1;
        u.prs2    = prs2;
        u.use_imm = use_imm;
        u.imm     = imm;
        dispatch_uop_i   = u;
        dispatch_valid_i = 1'b1;
        while (!dispatch_ready_o) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        dispatch_valid_i = 1'b0;
    endtask

    task automatic wait_all_written();
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < 300) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (outstanding != 0) begin
            for (int t = 0; t < TAG_COUNT; t++) begin
                if (pending[t]) begin
                    $display("missing writeback for tag %0d", t);
                end
            end
            stop_run();
        end
    endtask

    task automatic test_alu_ops();
        preg_t    ra;
        preg_t    rb;
        preg_t    rd;
        rob_tag_t t;
        fresh_preg(ra);
        send(OP_LI, ra, '0, '0, 1'b1, 32'hF00F_1234, t);
        fresh_preg(rb);
        send(OP_LI, rb, '0, '0, 1'b1, 32'h0000_0113, t);
        // codes 0..7 are the register-register ALU ops
        for (int i = 0; i < 8; i++) begin
            fresh_preg(rd);
            send(fu_op_e'(4'(i)), rd, ra, rb, 1'b0, '0, t);
        end
        fresh_preg(rd);
        send(OP_ADD, rd, ra, '0, 1'b1, 32'h0000_0010, t);
        wait_all_written();
    endtask

    task automatic test_dependency_chain();
        preg_t    prev;
        preg_t    rd;
        rob_tag_t tags [7];
        fresh_preg(prev);
        send(OP_LI, prev, '0, '0, 1'b1, 32'd5, tags[0]);
        for (int i = 1; i < 7; i++) begin
            fresh_preg(rd);
            send(fu_op_e'(4'(((i - 1) * 3) % 8)), rd, prev, prev, (i % 2) == 1,
                 32'(i + 3), tags[i]);
            prev = rd;
        end
        wait_all_written();
        for (int i = 1; i < 7; i++) begin
            check_value("chain writeback order",
                        32'(wb_cycle[tags[i]] > wb_cycle[tags[i - 1]]), 32'd1);
        end
    endtask

    task automatic test_mul_overtaken();
        preg_t    x;
        preg_t    y;
        preg_t    rd;
        rob_tag_t t;
        rob_tag_t mt;
        rob_tag_t at [4];
        fresh_preg(x);
        send(OP_LI, x, '0, '0, 1'b1, 32'h1234_5678, t);
        fresh_preg(y);
        send(OP_LI, y, '0, '0, 1'b1, 32'h9ABC_DEF1, t);
        fresh_preg(rd);
        send(OP_MUL, rd, x, y, 1'b0, '0, mt);
        for (int i = 0; i < 4; i++) begin
            fresh_preg(rd);
            send(fu_op_e'(4'(i + 1)), rd, x, y, 1'b0, '0, at[i]);
        end
        wait_all_written();
        for (int i = 0; i < 4; i++) begin
            check_value("alu writeback before mul", 32'(wb_cycle[at[i]] < wb_cycle[mt]), 32'd1);
        end
    endtask

    task automatic test_back_pressure();
        preg_t    x;
        preg_t    m;
        preg_t    rd;
        rob_tag_t t;
        rob_tag_t mt;
        fresh_preg(x);
        send(OP_LI, x, '0, '0, 1'b1, 32'd3, t);
        wait_all_written();
        fresh_preg(m);
        send(OP_MUL, m, x, '0, 1'b1, 32'h0001_0001, mt);
        for (int i = 0; i < IQ_DEPTH; i++) begin
            fresh_preg(rd);
            send(OP_ADD, rd, m, '0, 1'b1, 32'(i), t);
        end
        // every queue entry now waits on the multiply
        check_value("dispatch_ready_o while full", 32'(dispatch_ready_o), 32'd0);
        check_value("multiply still pending", 32'(pending[mt]), 32'd1);
        while (!dispatch_ready_o) begin
            @(posedge clk);
            #1;
        end
        check_value("multiply pending at reopen", 32'(pending[mt]), 32'd0);
        wait_all_written();
    endtask

    task automatic test_random_mix();
        preg_t    pool [24];
        int       n;
        int       r;
        preg_t    rd;
        fu_op_e   op;
        rob_tag_t t;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            fresh_preg(rd);
            send(OP_LI, rd, '0, '0, 1'b1, $random(seed), t);
            pool[n] = rd;
            n++;
        end
        for (int i = 0; i < 20; i++) begin
            op = fu_op_e'(4'($unsigned($random(seed)) % 10));
            r  = $random(seed);
            fresh_preg(rd);
            send(op, rd, pool[$unsigned($random(seed)) % n], pool[$unsigned($random(seed)) % n],
                 r[0], $random(seed), t);
            pool[n] = rd;
            n++;
        end
        wait_all_written();
    endtask

    initial begin
        reset_i          = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_uop_i   = '0;
        next_tag         = '0;
        next_preg        = preg_t'(1);
        seed             = 26332;
        for (int i = 0; i < PREG_COUNT; i++) begin
            exp_reg[i] = '0;
        end
        for (int i = 0; i < TAG_COUNT; i++) begin
            pending[i]  = 1'b0;
            written[i]  = 1'b0;
            wb_cycle[i] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_value("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
        check_value("dispatch_ready_o after reset", 32'(dispatch_ready_o), 32'd1);
        check_value("busy bits clear after reset", 32'(DUT.busy == '0), 32'd1);

        test_alu_ops();
        test_dependency_chain();
        test_mul_overtaken();
        test_back_pressure();
        test_random_mix();

        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim.f
backend_pkg.sv
scoreboard.sv
issue_queue.sv
prf.sv
alu_pipe.sv
mul_unit.sv
wb_arbiter.sv
backend_top.sv
tb_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
